// File: common/swPkg.sv
// router shared definitions

package swPkg;

	////////////////////////////////////////////////////////////////////////////
	// crossbar geometry
	//
	localparam int PORTS      = 4;  // input ports = output ports
	localparam int PORT_W     = 2;  // width of a port index

	// the first character of a packet carries the path address
	localparam int ADDR_W     = 8;  // header address field, valid when below PORTS

	////////////////////////////////////////////////////////////////////////////
	// crosspoint buffers
	//
	localparam int CELL_DEPTH = 8;  // characters per crosspoint, power of two
	localparam int CNT_W      = 4;  // occupancy 0..CELL_DEPTH, pointers use CNT_W-1

	////////////////////////////////////////////////////////////////////////////
	// character format
	//
	// 9-bit character
	//   [8]   end of packet
	//   [7:0] data byte
	localparam int EOP_BIT    = 8;

	typedef logic [8:0] charT;

endpackage

// File: switchMatrix/crossCell.sv
// crosspoint FIFO cell
`timescale 1ns/1ps

module crossCell
(
	input  logic        gclk,
	input  logic        reset,
	input  logic        wr_i,      // write strobe from the row
	input  swPkg::charT wrData_i,  // character from the input port
	input  logic        rd_i,      // pop strobe from the column
	output swPkg::charT rdData_o,  // head character, fall-through
	output logic        empty_o,
	output logic        full_o
);
	import swPkg::*;

	charT             mem [CELL_DEPTH];  // character storage
	logic [CNT_W-2:0] wrPtr;             // wraps at CELL_DEPTH
	logic [CNT_W-2:0] rdPtr;
	logic [CNT_W-1:0] count;             // characters held
	logic             doWr;
	logic             doRd;

	// a write into a full cell or a pop of an empty one is ignored
	assign doWr = wr_i && !full_o;
	assign doRd = rd_i && !empty_o;

	always_ff @(posedge gclk)
	begin
		if (doWr)
			mem[wrPtr] <= wrData_i;
	end

	always_ff @(posedge gclk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= wrPtr + 1'b1;
			if (doRd)
				rdPtr <= rdPtr + 1'b1;
			case ({doWr, doRd})
				2'b10:   count <= count + 1'b1;  // write only
				2'b01:   count <= count - 1'b1;  // pop only
				default: count <= count;         // both or none
			endcase
		end
	end

	assign empty_o  = (count == '0);
	assign full_o   = (count == CNT_W'(CELL_DEPTH));
	assign rdData_o = mem[rdPtr];  // head visible one cycle after the write

endmodule

// File: switchMatrix/columnScheduler.sv
// output column round-robin scheduler
`timescale 1ns/1ps

module columnScheduler
(
	input  logic                     gclk,
	input  logic                     reset,
	input  logic [swPkg::PORTS-1:0]  cellEmpty_i,  // one flag per row of this column
	input  logic                     headEop_i,    // eop bit of the granted head character
	input  logic                     popAccept_i,  // granted cell popped this cycle
	output logic [swPkg::PORT_W-1:0] grant_o,      // granted row
	output logic                     grantValid_o
);
	import swPkg::*;

	logic [PORT_W-1:0] grant;       // current grant, last grant when idle
	logic              grantValid;
	logic [PORT_W-1:0] pick;        // next row in round-robin order
	logic              found;

	////////////////////////////////////////////////////////////////////////////
	// search the rows after the last grant
	//
	always_comb
	begin
		logic [PORT_W-1:0] idx;
		pick  = grant;
		found = 1'b0;
		// offset PORTS comes back to the last row, so it is tried last
		for (int i = 1; i <= PORTS; i++)
		begin
			idx = PORT_W'((int'(grant) + i) % PORTS);
			if (!found && !cellEmpty_i[idx])
			begin
				pick  = idx;
				found = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// grant register, held for a whole packet
	//
	always_ff @(posedge gclk)
	begin
		if (reset)
		begin
			grant      <= PORT_W'(PORTS - 1);  // row 0 wins first
			grantValid <= 1'b0;
		end
		else if (!grantValid)
		begin
			if (found)
			begin
				grant      <= pick;
				grantValid <= 1'b1;
			end
		end
		else if (popAccept_i && headEop_i)
			grantValid <= 1'b0;  // eop read, re-arbitrate next cycle
	end

	// the grant survives a cell running dry mid-packet, the column just waits
	assign grant_o      = grant;
	assign grantValid_o = grantValid;

endmodule

// File: switchMatrix/switchMatrix.sv
// buffered crossbar matrix
`timescale 1ns/1ps

module switchMatrix
(
	input  logic                                         gclk,
	input  logic                                         reset,
	// rows, one per input port
	input  logic [swPkg::PORTS-1:0]                      sopReq_i,
	input  logic [swPkg::PORTS-1:0][swPkg::PORT_W-1:0]   outAddr_i,
	output logic [swPkg::PORTS-1:0]                      sopAck_o,
	input  swPkg::charT [swPkg::PORTS-1:0]               rowData_i,
	input  logic [swPkg::PORTS-1:0]                      rowWr_i,
	output logic [swPkg::PORTS-1:0]                      rowSpace_o,
	// columns, one per output port
	output swPkg::charT [swPkg::PORTS-1:0]               outData_o,
	output logic [swPkg::PORTS-1:0]                      outValid_o,
	input  logic [swPkg::PORTS-1:0]                      outReady_i
);
	import swPkg::*;

	// cell arrays are indexed [column q][row p]
	wire charT              cellData  [PORTS][PORTS];
	wire  [PORTS-1:0]       cellEmpty [PORTS];
	wire  [PORTS-1:0]       cellFull  [PORTS];
	logic [PORTS-1:0]       cellWr    [PORTS];
	logic [PORTS-1:0]       cellRd    [PORTS];
	logic [PORT_W-1:0]      selCol    [PORTS];  // column latched per row
	logic [PORTS-1:0]       sopAck;
	wire  [PORT_W-1:0]      grant     [PORTS];  // granted row per column
	wire  [PORTS-1:0]       grantValid;
	logic [PORTS-1:0]       colPop;             // accepted transfer per column

	////////////////////////////////////////////////////////////////////////////
	// row side, start-of-packet handshake
	//
	always_ff @(posedge gclk)
	begin
		for (int p = 0; p < PORTS; p++)
		begin
			if (reset)
			begin
				sopAck[p] <= 1'b0;
				selCol[p] <= '0;
			end
			else if (sopReq_i[p] && !sopAck[p] && !cellFull[outAddr_i[p]][p])
			begin
				sopAck[p] <= 1'b1;           // ack once the addressed cell has room
				selCol[p] <= outAddr_i[p];
			end
			else if (!sopReq_i[p] && sopAck[p])
				sopAck[p] <= 1'b0;           // request released after eop
		end
	end

	assign sopAck_o = sopAck;

	// steering and pops
	always_comb
	begin
		for (int q = 0; q < PORTS; q++)
		begin
			for (int p = 0; p < PORTS; p++)
			begin
				cellWr[q][p] = rowWr_i[p] && sopAck[p] && (selCol[p] == PORT_W'(q));
				cellRd[q][p] = colPop[q] && (grant[q] == PORT_W'(p));
			end
		end
		for (int p = 0; p < PORTS; p++)
			rowSpace_o[p] = sopAck[p] && !cellFull[selCol[p]][p];  // space in the row's cell
	end

	////////////////////////////////////////////////////////////////////////////
	// column side, output multiplexers
	//
	always_comb
	begin
		for (int q = 0; q < PORTS; q++)
		begin
			outData_o[q]  = cellData[q][grant[q]];
			outValid_o[q] = grantValid[q] && !cellEmpty[q][grant[q]];
			colPop[q]     = outValid_o[q] && outReady_i[q];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// cell array and schedulers
	//
	for (genvar q = 0; q < PORTS; q++)
	begin : genCol
		for (genvar p = 0; p < PORTS; p++)
		begin : genRow
			crossCell u_cell
			(
				.gclk     (gclk),
				.reset    (reset),
				.wr_i     (cellWr[q][p]),
				.wrData_i (rowData_i[p]),     // a row feeds every cell of it
				.rd_i     (cellRd[q][p]),
				.rdData_o (cellData[q][p]),
				.empty_o  (cellEmpty[q][p]),
				.full_o   (cellFull[q][p])
			);
		end

		columnScheduler u_sched
		(
			.gclk         (gclk),
			.reset        (reset),
			.cellEmpty_i  (cellEmpty[q]),
			.headEop_i    (cellData[q][grant[q]][EOP_BIT]),
			.popAccept_i  (colPop[q]),
			.grant_o      (grant[q]),
			.grantValid_o (grantValid[q])
		);
	end

endmodule

// File: hdl/inputPort.sv
// input port packet handler
`timescale 1ns/1ps

module inputPort
(
	input  logic                     gclk,
	input  logic                     reset,
	input  swPkg::charT              inData_i,
	input  logic                     inValid_i,
	output logic                     inReady_o,
	output logic                     sopReq_o,    // four-phase request to the matrix row
	output logic [swPkg::PORT_W-1:0] outAddr_o,   // column, stable while requesting
	input  logic                     sopAck_i,
	input  logic                     rowSpace_i,  // selected cell not full
	output swPkg::charT              rowData_o,
	output logic                     rowWr_o
);
	import swPkg::*;

	typedef enum logic [2:0] {IDLE, HEADER, REQUEST, STREAM, RELEASE, DISCARD} stateT;

	stateT             state;
	logic              take;     // character consumed this cycle
	logic [ADDR_W-1:0] hdrAddr;  // path address field of the header

	assign take    = inValid_i && inReady_o;
	assign hdrAddr = inData_i[ADDR_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// packet FSM
	//
	always_ff @(posedge gclk)
	begin
		if (reset)
		begin
			state     <= IDLE;
			outAddr_o <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					state <= HEADER;
				HEADER:
					// an eop header is an empty packet, dropped in place
					if (take && !inData_i[EOP_BIT])
					begin
						if (hdrAddr < ADDR_W'(PORTS))
						begin
							outAddr_o <= hdrAddr[PORT_W-1:0];  // header deleted here
							state     <= REQUEST;
						end
						else
							state <= DISCARD;  // no such output port
					end
				REQUEST:
					if (sopAck_i)
						state <= STREAM;
				STREAM:
					if (rowWr_o && inData_i[EOP_BIT])
						state <= RELEASE;  // eop written, drop the request
				RELEASE:
					if (!sopAck_i)
						state <= HEADER;   // handshake complete
				DISCARD:
					if (take && inData_i[EOP_BIT])
						state <= HEADER;
				default:
					state <= IDLE;
			endcase
		end
	end

	// ready follows the state, cell space while streaming
	always_comb
	begin
		case (state)
			HEADER, DISCARD: inReady_o = 1'b1;
			STREAM:          inReady_o = rowSpace_i;
			default:         inReady_o = 1'b0;
		endcase
	end

	assign sopReq_o  = (state == REQUEST) || (state == STREAM);
	assign rowData_o = inData_i;  // payload goes straight to the row
	assign rowWr_o   = (state == STREAM) && inValid_i && rowSpace_i;

endmodule

// File: hdl/routerCore.sv
// packet router core
`timescale 1ns/1ps

module routerCore
(
	input  logic                        gclk,
	input  logic                        reset,
	input  swPkg::charT [swPkg::PORTS-1:0] inData_i,
	input  logic [swPkg::PORTS-1:0]     inValid_i,
	output logic [swPkg::PORTS-1:0]     inReady_o,
	output swPkg::charT [swPkg::PORTS-1:0] outData_o,
	output logic [swPkg::PORTS-1:0]     outValid_o,
	input  logic [swPkg::PORTS-1:0]     outReady_i
);
	import swPkg::*;

	wire [PORTS-1:0]             sopReq;   // row handshake
	wire [PORTS-1:0]             sopAck;
	wire [PORTS-1:0][PORT_W-1:0] outAddr;
	wire charT [PORTS-1:0]       rowData;  // row write path
	wire [PORTS-1:0]             rowWr;
	wire [PORTS-1:0]             rowSpace;

	for (genvar p = 0; p < PORTS; p++)
	begin : genIn
		inputPort u_inPort
		(
			.gclk       (gclk),
			.reset      (reset),
			.inData_i   (inData_i[p]),
			.inValid_i  (inValid_i[p]),
			.inReady_o  (inReady_o[p]),
			.sopReq_o   (sopReq[p]),
			.outAddr_o  (outAddr[p]),
			.sopAck_i   (sopAck[p]),
			.rowSpace_i (rowSpace[p]),
			.rowData_o  (rowData[p]),
			.rowWr_o    (rowWr[p])
		);
	end

	switchMatrix u_matrix
	(
		.gclk       (gclk),
		.reset      (reset),
		.sopReq_i   (sopReq),
		.outAddr_i  (outAddr),
		.sopAck_o   (sopAck),
		.rowData_i  (rowData),
		.rowWr_i    (rowWr),
		.rowSpace_o (rowSpace),
		.outData_o  (outData_o),
		.outValid_o (outValid_o),
		.outReady_i (outReady_i)
	);

endmodule

// File: dv/routerCore_props.sv
// crossbar handshake properties
`timescale 1ns/1ps

module routerCore_props
(
	input logic                             gclk,
	input logic                             reset,
	input logic        [swPkg::PORTS-1:0]   sopReq_i,
	input logic        [swPkg::PORTS-1:0]   sopAck_o,
	input swPkg::charT [swPkg::PORTS-1:0]   outData_o,
	input logic        [swPkg::PORTS-1:0]   outValid_o,
	input logic        [swPkg::PORTS-1:0]   outReady_i
);
	import swPkg::*;

	for (genvar i = 0; i < PORTS; i++)
	begin : genChk
		// ack is registered from the request of the cycle before
		ackNeedsReq: assert property (@(posedge gclk) disable iff (reset)
			$rose(sopAck_o[i]) |-> $past(sopReq_i[i]))
			else $error("row %0d acknowledged without a request", i);

		// phase 1 holds until the matrix answers
		reqHoldsForAck: assert property (@(posedge gclk) disable iff (reset)
			sopReq_i[i] && !sopAck_o[i] |=> sopReq_i[i])
			else $error("row %0d dropped its request before the ack", i);

		// a stalled column keeps its head character
		outHoldsOnStall: assert property (@(posedge gclk) disable iff (reset)
			outValid_o[i] && !outReady_i[i] |=> outValid_o[i] && $stable(outData_o[i]))
			else $error("column %0d changed its output while stalled", i);
	end

endmodule

bind switchMatrix routerCore_props u_props (.*);

// File: dv/routerCore_tb.sv
// router core testbench
`timescale 1ns/1ps

module routerCore_tb;
	import swPkg::*;

	localparam logic [31:0] SEED       = 32'h248c_9f0f;
	localparam int          CHAR_LIMIT = 40;  // watchdog cycles per character sent
	localparam int          STALL_LEN  = 20;  // payload of the packet into the stalled output

	logic                    gclk;
	logic                    reset;
	charT [PORTS-1:0]        inData_i;
	logic [PORTS-1:0]        inValid_i;
	wire  [PORTS-1:0]        inReady_o;
	wire  charT [PORTS-1:0]  outData_o;
	wire  [PORTS-1:0]        outValid_o;
	logic [PORTS-1:0]        outReady_i;

	charT        txQ   [PORTS][$];         // characters still to send including headers
	charT        expQ  [PORTS][PORTS][$];  // expected characters per [input][output]
	int          lenQ  [PORTS][PORTS][$];  // expected packet lengths per [input][output]
	charT        rxBuf [PORTS][$];         // packet being collected per output
	logic [5:0]  seqNo [PORTS];            // tag byte makes each packet unique
	logic [31:0] stimState;
	logic [31:0] bpState;                  // separate stream for back-pressure
	logic [PORTS-1:0] stallMask;
	logic        randomBp;
	int          totalChars;
	int          cycles;
	int          errors;
	int          checks;
	int          testsRun;
	int          testsFailed;

	routerCore u_dut (.*);

	initial
	begin
		gclk = 1'b0;
		forever #10 gclk = ~gclk;  // 20 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	//
	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int takeBits(inout logic [31:0] s, input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			s = lfsrStep(s);     // one step per bit
			v = (v << 1) | s[0];
		end
		return v;
	endfunction

	// the header is dropped and an address below PORTS picks the output
	function automatic int routeOf(input charT header);
		if (header[ADDR_W-1:0] < ADDR_W'(PORTS))
			return int'(header[ADDR_W-1:0]);
		return -1;  // no such port so the packet is discarded
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		for (int p = 0; p < PORTS; p++)
		begin
			n += txQ[p].size() + rxBuf[p].size();
			for (int q = 0; q < PORTS; q++)
				n += lenQ[p][q].size();
		end
		return n;
	endfunction

	// header plus len payload characters with eop on the last one
	task automatic queuePacket(input int src, input int addr, input int len);
		charT c;
		int   dest;
		c = {1'b0, 8'(addr)};
		dest = routeOf(c);
		txQ[src].push_back(c);
		for (int i = 0; i < len; i++)
		begin
			c[7:0] = (i == 0) ? {2'(src), seqNo[src]} : 8'(takeBits(stimState, 8));
			c[EOP_BIT] = (i == len - 1);
			txQ[src].push_back(c);
			if (dest >= 0)
				expQ[src][dest].push_back(c);
		end
		if (dest >= 0)
			lenQ[src][dest].push_back(len);
		seqNo[src]++;
		totalChars += len + 1;  // watchdog budget grows with traffic
	endtask

	task automatic drain();
		while (pending() > 0)
			@(posedge gclk);
		repeat (10) @(posedge gclk);  // catch stray late packets
		@(negedge gclk);              // next test starts between rising edges
	endtask

	task automatic endTest(input string name, input int errBefore);
		testsRun++;
		if (errors == errBefore)
			$display("test %0d %s: ok", testsRun, name);
		else
		begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testsRun, name, errors - errBefore);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drivers update on the rising edge
	//
	always @(posedge gclk)
	begin
		for (int p = 0; p < PORTS; p++)
		begin
			if (reset)
				inValid_i[p] <= 1'b0;
			else
			begin
				if (inValid_i[p] && inReady_o[p])
					void'(txQ[p].pop_front());  // character taken last cycle
				if (txQ[p].size() > 0)
				begin
					inData_i[p]  <= txQ[p][0];
					inValid_i[p] <= 1'b1;
				end
				else
					inValid_i[p] <= 1'b0;
			end
		end
	end

	always @(posedge gclk)
	begin
		for (int q = 0; q < PORTS; q++)
		begin
			if (stallMask[q])
				outReady_i[q] <= 1'b0;
			else if (randomBp)
				outReady_i[q] <= (takeBits(bpState, 2) != 0);  // ready 3 of 4
			else
				outReady_i[q] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// scoreboard
	//
	task automatic matchPacket(input int q);
		int  found;
		logic same;
		found = -1;
		for (int p = 0; p < PORTS; p++)
		begin
			if (found < 0 && lenQ[p][q].size() > 0 && lenQ[p][q][0] == rxBuf[q].size())
			begin
				same = 1'b1;
				for (int i = 0; i < rxBuf[q].size(); i++)
					if (expQ[p][q][i] != rxBuf[q][i])
						same = 1'b0;
				if (same)
					found = p;
			end
		end
		checks++;
		assert (found >= 0)
		else
		begin
			$display("[FAIL] t=%0t output %0d got a %0d-char packet matching no queue head",
				$time, q, rxBuf[q].size());
			errors++;
		end
		if (found >= 0)
		begin
			void'(lenQ[found][q].pop_front());
			repeat (rxBuf[q].size()) void'(expQ[found][q].pop_front());
		end
		rxBuf[q].delete();
	endtask

	// pre-edge values are sampled and eop closes the packet
	always @(posedge gclk)
	begin
		if (!reset)
			for (int q = 0; q < PORTS; q++)
				if (outValid_o[q] && outReady_i[q])
				begin
					rxBuf[q].push_back(outData_o[q]);
					if (outData_o[q][EOP_BIT])
						matchPacket(q);
				end
	end

	initial
	begin
		cycles = 0;
		while (cycles <= 200 + totalChars * CHAR_LIMIT)
		begin
			@(posedge gclk);
			cycles++;
		end
		$display("watchdog expired after %0d cycles, traffic never drained", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// tests
	//
	initial
	begin
		int errBefore;
		int lowRun;
		int waited;
		inData_i   = '0;
		inValid_i  = '0;
		outReady_i = '0;
		stallMask  = '0;
		randomBp   = 1'b0;
		stimState  = SEED;
		bpState    = SEED;
		totalChars = 0;
		errors     = 0;
		checks     = 0;
		testsRun   = 0;
		testsFailed = 0;
		for (int p = 0; p < PORTS; p++)
			seqNo[p] = '0;
		reset = 1'b1;
		repeat (2) @(posedge gclk);
		reset <= 1'b0;

		errBefore = errors;
		for (int p = 0; p < PORTS; p++)
			queuePacket(p, (p + 1) % PORTS, 3 + p);  // distinct outputs
		drain();
		endTest("one packet per input", errBefore);

		errBefore = errors;
		for (int k = 0; k < 3; k++)
			for (int p = 0; p < PORTS; p++)
				queuePacket(p, 2, 2 + takeBits(stimState, 3));  // all into output 2
		drain();
		endTest("many to one", errBefore);

		errBefore = errors;
		randomBp = 1'b1;
		for (int k = 0; k < 10; k++)
			for (int p = 0; p < PORTS; p++)
				queuePacket(p, takeBits(stimState, 2), 1 + takeBits(stimState, 4));
		drain();
		randomBp = 1'b0;
		endTest("random traffic", errBefore);

		errBefore = errors;
		queuePacket(0, 5, 4);    // invalid address followed by a valid packet
		queuePacket(0, 1, 3);
		queuePacket(1, 255, 6);
		queuePacket(1, 3, 2);
		drain();
		endTest("invalid address", errBefore);

		errBefore = errors;
		stallMask = 4'b0001;
		queuePacket(0, 0, STALL_LEN);   // longer than one cell
		for (int k = 0; k < 3; k++)
			queuePacket(1, 1, 6);
		lowRun = 0;
		waited = 0;
		while (lowRun < 12 && waited < 400)
		begin
			@(posedge gclk);
			waited++;
			lowRun = (inValid_i[0] && !inReady_o[0]) ? lowRun + 1 : 0;
		end
		assert (lowRun >= 12)
		else
		begin
			$display("input 0 never saw back-pressure from the stalled output");
			errors++;
		end
		// header deleted, one full cell takes CELL_DEPTH payload characters
		assert (txQ[0].size() == STALL_LEN - CELL_DEPTH)
		else
		begin
			$display("[FAIL] t=%0t stalled input 0 took %0d payload chars, expected %0d",
				$time, STALL_LEN - txQ[0].size(), CELL_DEPTH);
			errors++;
		end
		waited = 0;
		while (lenQ[1][1].size() > 0 && waited < 400)
		begin
			@(posedge gclk);
			waited++;
		end
		assert (lenQ[1][1].size() == 0)
		else
		begin
			$display("output 1 stopped delivering while output 0 was stalled");
			errors++;
		end
		@(negedge gclk);
		stallMask = '0;
		drain();
		endTest("stalled output", errBefore);

		$display("tests %0d, failed %0d, packets checked %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: compile.f
common/swPkg.sv
switchMatrix/crossCell.sv
switchMatrix/columnScheduler.sv
switchMatrix/switchMatrix.sv
hdl/inputPort.sv
hdl/routerCore.sv
dv/routerCore_props.sv
dv/routerCore_tb.sv
